// ==== hw/attn_types_pkg.sv ====
/*
 * Attention engine data types.
 * Matrix side and the widths of elements, projections, scores
 * and output values for one head with d_model 8.
 */
`default_nettype none

package attn_types_pkg;

    // matrix side, one head
    localparam int D_MODEL = 8;

    // X and weight elements as they arrive
    typedef logic signed [7:0]  elem_t;

    // holds a sum of eight 16-bit products
    typedef logic signed [18:0] proj_t;

    // relu(q.k) / 3, never negative
    typedef logic        [39:0] score_t;

    // one element of O = S.V
    typedef logic signed [62:0] out_t;

    typedef logic [3:0] rows_t;
    typedef logic [2:0] idx_t;

endpackage

`default_nettype wire

// ==== hw/attn_ctrl_pkg.sv ====
/*
 * Attention engine control definitions.
 * Phases of the compute sequence and the input burst layout.
 */
`default_nettype none

package attn_ctrl_pkg;

    // compute phases, one dot product issued per cycle outside IDLE and LOAD
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        PROJ_Q,
        PROJ_K,
        PROJ_V,
        SCORE,
        MIX
    } phase_e;

    // in_valid burst length, and the cycles taken by each weight matrix
    localparam int LOAD_CYCLES = 192;
    localparam int W_BLOCK     = 64;

endpackage

`default_nettype wire

// ==== hw/attn_loader.sv ====
/*
 * Attention input loader.
 * Counts the in_valid burst, latches T on the first cycle and
 * stores X, W_Q, W_K and W_V at their row-major positions.
 */
`timescale 1ns/1ns
`default_nettype none

module attn_loader import attn_types_pkg::*, attn_ctrl_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  wire rows_t  t_rows,
    input  wire elem_t  in_x,
    input  wire elem_t  w_q,
    input  wire elem_t  w_k,
    input  wire elem_t  w_v,
    output rows_t       rows,
    output elem_t       x_mat  [D_MODEL][D_MODEL],
    output elem_t       wq_mat [D_MODEL][D_MODEL],
    output elem_t       wk_mat [D_MODEL][D_MODEL],
    output elem_t       wv_mat [D_MODEL][D_MODEL],
    output logic        load_start,
    output logic        load_done
);

    logic [7:0] cnt;
    logic       first;
    logic       last;
    rows_t      rows_now;
    logic       x_en;
    idx_t       r;
    idx_t       c;

    assign first    = in_valid && (cnt == '0);
    assign last     = in_valid && (cnt == 8'(LOAD_CYCLES - 1));
    // T is not latched yet on the first cycle
    assign rows_now = first ? t_rows : rows;
    assign x_en     = in_valid && (cnt < {1'b0, rows_now, 3'b000});
    assign r        = cnt[5:3];
    assign c        = cnt[2:0];

    assign load_start = first;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            rows      <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= last;
            if (first)
                rows <= t_rows;
            if (in_valid)
                cnt <= last ? '0 : cnt + 8'd1;
        end
    end

    // ####################
    // matrix capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < D_MODEL; i++) begin
                for (int j = 0; j < D_MODEL; j++) begin
                    x_mat[i][j]  <= '0;
                    wq_mat[i][j] <= '0;
                    wk_mat[i][j] <= '0;
                    wv_mat[i][j] <= '0;
                end
            end
        end else if (in_valid) begin
            // rows at or beyond T stay zero for this job
            if (first) begin
                for (int i = 0; i < D_MODEL; i++) begin
                    for (int j = 0; j < D_MODEL; j++)
                        x_mat[i][j] <= '0;
                end
            end
            if (x_en)
                x_mat[r][c] <= in_x;
            if (cnt < 8'(W_BLOCK))
                wq_mat[r][c] <= w_q;
            else if (cnt < 8'(2 * W_BLOCK))
                wk_mat[r][c] <= w_k;
            else
                wv_mat[r][c] <= w_v;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dot8_unit.sv ====
/*
 * Eight-lane signed dot product.
 * Multiplies the lanes of two vectors and registers the sum,
 * so the result follows its operands by one cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module dot8_unit import attn_types_pkg::*; #(
    parameter int A_W = 8,
    parameter int B_W = 8,
    parameter int Z_W = 19
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [D_MODEL*A_W-1:0]   a_vec,
    input  wire [D_MODEL*B_W-1:0]   b_vec,
    output logic signed [Z_W-1:0]   z
);

    logic signed [Z_W-1:0] sum;

    always_comb begin
        logic signed [A_W-1:0]     a_lane;
        logic signed [B_W-1:0]     b_lane;
        logic signed [A_W+B_W-1:0] prod;
        sum = '0;
        for (int k = 0; k < D_MODEL; k++) begin
            a_lane = a_vec[k*A_W +: A_W];
            b_lane = b_vec[k*B_W +: B_W];
            prod   = a_lane * b_lane;
            // sign-extend each product into the sum width
            sum    = sum + Z_W'(prod);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            z <= '0;
        else
            z <= sum;
    end

endmodule

`default_nettype wire

// ==== hw/attn_matrix_store.sv ====
/*
 * Attention matrix store.
 * Holds Q, K, V and the scores, selects the dot unit operands from
 * the current phase and indices, and writes each dot result back one
 * cycle later. Scores pass through ReLU and a divide by three.
 */
`timescale 1ns/1ns
`default_nettype none

module attn_matrix_store import attn_types_pkg::*, attn_ctrl_pkg::*; #(
    parameter int ELEM_W  = 8,
    parameter int PROJ_W  = 19,
    parameter int SCORE_W = 40,
    parameter int OUT_W   = 63
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              load_start,
    input  wire                              issue,
    input  wire phase_e                      phase,
    input  wire idx_t                        row_idx,
    input  wire idx_t                        col_idx,
    input  wire elem_t                       x_mat  [D_MODEL][D_MODEL],
    input  wire elem_t                       wq_mat [D_MODEL][D_MODEL],
    input  wire elem_t                       wk_mat [D_MODEL][D_MODEL],
    input  wire elem_t                       wv_mat [D_MODEL][D_MODEL],
    input  wire [PROJ_W-1:0]                 proj_z,
    input  wire [OUT_W-1:0]                  wide_z,
    output logic [D_MODEL*ELEM_W-1:0]        proj_a,
    output logic [D_MODEL*ELEM_W-1:0]        proj_b,
    output logic [D_MODEL*(SCORE_W+1)-1:0]   wide_a,
    output logic [D_MODEL*PROJ_W-1:0]        wide_b
);

    localparam int WA_W = SCORE_W + 1;

    proj_t  q_mat [D_MODEL][D_MODEL];
    proj_t  k_mat [D_MODEL][D_MODEL];
    proj_t  v_mat [D_MODEL][D_MODEL];
    score_t s_mat [D_MODEL][D_MODEL];

    // where the result of the previous issue goes
    logic   tag_valid;
    phase_e tag_phase;
    idx_t   tag_row;
    idx_t   tag_col;

    logic [OUT_W-1:0] relu_z;
    logic [OUT_W-1:0] div3_z;

    // ####################
    // operand selection
    always_comb begin
        proj_t q_el;
        for (int k = 0; k < D_MODEL; k++) begin
            proj_a[k*ELEM_W +: ELEM_W] = x_mat[row_idx][k];
            case (phase)
                PROJ_Q:  proj_b[k*ELEM_W +: ELEM_W] = wq_mat[k][col_idx];
                PROJ_K:  proj_b[k*ELEM_W +: ELEM_W] = wk_mat[k][col_idx];
                default: proj_b[k*ELEM_W +: ELEM_W] = wv_mat[k][col_idx];
            endcase
            q_el = q_mat[row_idx][k];
            if (phase == SCORE) begin
                // Q row i against K row j, i.e. a column of K transposed
                wide_a[k*WA_W +: WA_W]     = {{(WA_W - PROJ_W){q_el[PROJ_W-1]}}, q_el};
                wide_b[k*PROJ_W +: PROJ_W] = k_mat[col_idx][k];
            end else begin
                // scores are unsigned, the zero top bit keeps them positive
                wide_a[k*WA_W +: WA_W]     = {1'b0, s_mat[row_idx][k]};
                // last score of SCORE is still in flight on the first MIX issue
                if (tag_valid && (tag_phase == SCORE) && (tag_row == row_idx) &&
                    (tag_col == idx_t'(k)))
                    wide_a[k*WA_W +: WA_W] = {1'b0, div3_z[SCORE_W-1:0]};
                wide_b[k*PROJ_W +: PROJ_W] = v_mat[k][col_idx];
            end
        end
    end

    // relu, then divide by three with truncation
    assign relu_z = wide_z[OUT_W-1] ? '0 : wide_z;
    assign div3_z = relu_z / OUT_W'(3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= 1'b0;
            tag_phase <= IDLE;
            tag_row   <= '0;
            tag_col   <= '0;
        end else begin
            tag_valid <= issue;
            tag_phase <= phase;
            tag_row   <= row_idx;
            tag_col   <= col_idx;
        end
    end

    // ####################
    // result write-back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < D_MODEL; i++) begin
                for (int j = 0; j < D_MODEL; j++) begin
                    q_mat[i][j] <= '0;
                    k_mat[i][j] <= '0;
                    v_mat[i][j] <= '0;
                    s_mat[i][j] <= '0;
                end
            end
        end else begin
            // score columns at or beyond T must read as zero in MIX
            if (load_start) begin
                for (int i = 0; i < D_MODEL; i++) begin
                    for (int j = 0; j < D_MODEL; j++)
                        s_mat[i][j] <= '0;
                end
            end
            if (tag_valid) begin
                case (tag_phase)
                    PROJ_Q:  q_mat[tag_row][tag_col] <= proj_z;
                    PROJ_K:  k_mat[tag_row][tag_col] <= proj_z;
                    PROJ_V:  v_mat[tag_row][tag_col] <= proj_z;
                    SCORE:   s_mat[tag_row][tag_col] <= div3_z[SCORE_W-1:0];
                    // MIX results leave the engine directly
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/attn_sequencer.sv ====
/*
 * Attention sequencer.
 * Walks the projection, score and mix phases with row and column
 * counters, issuing one dot product per cycle, and flags the
 * output values of the mix phase.
 */
`timescale 1ns/1ns
`default_nettype none

module attn_sequencer import attn_types_pkg::*, attn_ctrl_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire rows_t  rows,
    input  wire         load_done,
    output logic        issue,
    output phase_e      phase,
    output idx_t        row_idx,
    output idx_t        col_idx,
    output logic        out_valid
);

    phase_e state;
    phase_e next_phase;
    idx_t   last_row;
    idx_t   last_col;
    logic   row_end;
    logic   col_end;

    assign phase = state;
    assign issue = state inside {PROJ_Q, PROJ_K, PROJ_V, SCORE, MIX};

    // T is 1 to 8, so T-1 fits an index
    assign last_row = idx_t'(rows - 4'd1);
    // SCORE runs T x T, the other phases T x 8
    assign last_col = (state == SCORE) ? last_row : idx_t'(D_MODEL - 1);
    assign row_end  = (row_idx == last_row);
    assign col_end  = (col_idx == last_col);

    always_comb begin
        case (state)
            PROJ_Q:  next_phase = PROJ_K;
            PROJ_K:  next_phase = PROJ_V;
            PROJ_V:  next_phase = SCORE;
            SCORE:   next_phase = MIX;
            default: next_phase = IDLE;
        endcase
    end

    // ####################
    // phase FSM and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            row_idx <= '0;
            col_idx <= '0;
        end else if (issue) begin
            if (col_end) begin
                col_idx <= '0;
                if (row_end) begin
                    row_idx <= '0;
                    state   <= next_phase;
                end else begin
                    row_idx <= row_idx + 3'd1;
                end
            end else begin
                col_idx <= col_idx + 3'd1;
            end
        end else if (load_done) begin
            state   <= PROJ_Q;
            row_idx <= '0;
            col_idx <= '0;
        end
    end

    // the mix result appears one cycle after its issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= issue && (state == MIX);
    end

endmodule

`default_nettype wire

// ==== hw/attn_top.sv ====
/*
 * Single-head self-attention engine, d_model 8.
 * Loads X and the three weight matrices from one burst, then
 * streams O = (relu(Q.K^T) / 3) . V row-major.
 */
`timescale 1ns/1ns
`default_nettype none

module attn_top import attn_types_pkg::*, attn_ctrl_pkg::*; #(
    parameter int ELEM_W  = $bits(elem_t),
    parameter int PROJ_W  = $bits(proj_t),
    parameter int SCORE_W = $bits(score_t),
    parameter int OUT_W   = $bits(out_t)
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         in_valid,
    input  wire rows_t  t_rows,
    input  wire elem_t  in_x,
    input  wire elem_t  w_q,
    input  wire elem_t  w_k,
    input  wire elem_t  w_v,
    output wire         out_valid,
    output wire out_t   out_data
);

    rows_t  rows;
    elem_t  x_mat  [D_MODEL][D_MODEL];
    elem_t  wq_mat [D_MODEL][D_MODEL];
    elem_t  wk_mat [D_MODEL][D_MODEL];
    elem_t  wv_mat [D_MODEL][D_MODEL];
    logic   load_start;
    logic   load_done;
    logic   issue;
    phase_e phase;
    idx_t   row_idx;
    idx_t   col_idx;

    logic [D_MODEL*ELEM_W-1:0]      proj_a;
    logic [D_MODEL*ELEM_W-1:0]      proj_b;
    logic [PROJ_W-1:0]              proj_z;
    logic [D_MODEL*(SCORE_W+1)-1:0] wide_a;
    logic [D_MODEL*PROJ_W-1:0]      wide_b;

    attn_loader loader (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t_rows(t_rows),
        .in_x(in_x), .w_q(w_q), .w_k(w_k), .w_v(w_v), .rows(rows),
        .x_mat(x_mat), .wq_mat(wq_mat), .wk_mat(wk_mat), .wv_mat(wv_mat),
        .load_start(load_start), .load_done(load_done)
    );

    attn_sequencer sequencer (
        .clk(clk), .rst_n(rst_n), .rows(rows), .load_done(load_done),
        .issue(issue), .phase(phase), .row_idx(row_idx), .col_idx(col_idx),
        .out_valid(out_valid)
    );

    attn_matrix_store #(
        .ELEM_W(ELEM_W), .PROJ_W(PROJ_W), .SCORE_W(SCORE_W), .OUT_W(OUT_W)
    ) store (
        .clk(clk), .rst_n(rst_n), .load_start(load_start), .issue(issue),
        .phase(phase), .row_idx(row_idx), .col_idx(col_idx),
        .x_mat(x_mat), .wq_mat(wq_mat), .wk_mat(wk_mat), .wv_mat(wv_mat),
        .proj_z(proj_z), .wide_z(out_data),
        .proj_a(proj_a), .proj_b(proj_b), .wide_a(wide_a), .wide_b(wide_b)
    );

    // projections of X by the weights
    dot8_unit #(.A_W(ELEM_W), .B_W(ELEM_W), .Z_W(PROJ_W)) proj_dot (
        .clk(clk), .rst_n(rst_n), .a_vec(proj_a), .b_vec(proj_b), .z(proj_z)
    );

    // Q.K^T scores and the S.V output
    dot8_unit #(.A_W(SCORE_W + 1), .B_W(PROJ_W), .Z_W(OUT_W)) wide_dot (
        .clk(clk), .rst_n(rst_n), .a_vec(wide_a), .b_vec(wide_b), .z(out_data)
    );

endmodule

`default_nettype wire

// ==== tests/tb_attn.sv ====
/*
 * Testbench for the single-head attention engine.
 * Drives random jobs through the input burst, computes the expected
 * O = (relu(Q.K^T) / 3) . V in a reference model and checks every
 * streamed output value and the output count.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_attn import attn_types_pkg::*; ();

    localparam int NUM_JOBS   = 9;
    // longest job is about 530 cycles including the idle tail
    localparam int JOB_CYCLES = 700;
    localparam int MAX_CYCLES = 100 + NUM_JOBS * JOB_CYCLES;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    rows_t  t_rows;
    elem_t  in_x;
    elem_t  w_q;
    elem_t  w_k;
    elem_t  w_v;
    logic   out_valid;
    out_t   out_data;

    integer seed = 32'hf7b0_c19b;
    int     check_count = 0;
    int     error_count = 0;
    int     cycle_count = 0;
    int     errs_before;

    // model matrices, X rows at or beyond T are zero
    longint x_m  [8][8];
    longint wq_m [8][8];
    longint wk_m [8][8];
    longint wv_m [8][8];
    longint q_m  [8][8];
    longint k_m  [8][8];
    longint v_m  [8][8];
    longint s_m  [8][8];
    longint o_m  [8][8];

    attn_top dut0 (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t_rows(t_rows),
        .in_x(in_x), .w_q(w_q), .w_k(w_k), .w_v(w_v),
        .out_valid(out_valid), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: outputs did not arrive within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    task automatic check_value(input string name, input longint got, input longint exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        if (error_count == errs_at_start)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d mismatches", name, error_count - errs_at_start);
    endtask

    // ####################
    // job setup and model

    // all_neg gives Q > 0 and K < 0 everywhere, so every score is cleared
    task automatic make_job(input int t, input bit all_neg);
        for (int i = 0; i < 8; i++) begin
            for (int c = 0; c < 8; c++) begin
                if (i >= t)
                    x_m[i][c] = 0;
                else if (all_neg)
                    x_m[i][c] = rand_range(1, 15);
                else
                    x_m[i][c] = rand_range(-128, 127);
                wq_m[i][c] = all_neg ? rand_range(1, 15) : rand_range(-128, 127);
                wk_m[i][c] = all_neg ? rand_range(-15, -1) : rand_range(-128, 127);
                wv_m[i][c] = rand_range(-128, 127);
            end
        end
    endtask

    task automatic compute_expected(input int t);
        longint acc_q;
        longint acc_k;
        longint acc_v;
        longint acc;
        for (int i = 0; i < 8; i++) begin
            for (int c = 0; c < 8; c++) begin
                acc_q = 0;
                acc_k = 0;
                acc_v = 0;
                for (int m = 0; m < 8; m++) begin
                    acc_q += x_m[i][m] * wq_m[m][c];
                    acc_k += x_m[i][m] * wk_m[m][c];
                    acc_v += x_m[i][m] * wv_m[m][c];
                end
                q_m[i][c] = acc_q;
                k_m[i][c] = acc_k;
                v_m[i][c] = acc_v;
            end
        end
        // scores outside the T x T corner never contribute
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                acc = 0;
                for (int m = 0; m < 8; m++)
                    acc += q_m[i][m] * k_m[j][m];
                if (i >= t || j >= t || acc < 0)
                    s_m[i][j] = 0;
                else
                    s_m[i][j] = acc / 3;
            end
        end
        for (int i = 0; i < 8; i++) begin
            for (int c = 0; c < 8; c++) begin
                acc = 0;
                for (int j = 0; j < t; j++)
                    acc += s_m[i][j] * v_m[j][c];
                o_m[i][c] = acc;
            end
        end
    endtask

    // ####################
    // burst driver and output collector

    // unused slots of the burst carry random values that must be ignored
    task automatic drive_burst(input int t);
        int n;
        for (n = 0; n < 192; n++) begin
            @(negedge clk);
            in_valid = 1'b1;
            t_rows   = (n == 0) ? rows_t'(t) : rows_t'(rand_range(0, 15));
            in_x = (n < t * 8) ? elem_t'(x_m[n / 8][n % 8]) : elem_t'(rand_range(-128, 127));
            w_q  = (n < 64) ? elem_t'(wq_m[n / 8][n % 8]) : elem_t'(rand_range(-128, 127));
            if (n >= 64 && n < 128)
                w_k = elem_t'(wk_m[(n - 64) / 8][n % 8]);
            else
                w_k = elem_t'(rand_range(-128, 127));
            if (n >= 128)
                w_v = elem_t'(wv_m[(n - 128) / 8][n % 8]);
            else
                w_v = elem_t'(rand_range(-128, 127));
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_outputs(input int t);
        int got;
        got = 0;
        while (!out_valid)
            @(negedge clk);
        while (out_valid) begin
            if (got < t * 8)
                check_value($sformatf("out_data[%0d]", got), out_data, o_m[got / 8][got % 8]);
            got++;
            @(negedge clk);
        end
        check_value("output count", got, t * 8);
        // no stray values after the run
        repeat (20) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
        end
    endtask

    task automatic run_job(input int t, input bit all_neg);
        make_job(t, all_neg);
        compute_expected(t);
        drive_burst(t);
        collect_outputs(t);
    endtask

    // ####################
    // test sequence
    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        t_rows   = '0;
        in_x     = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        errs_before = error_count;
        repeat (30) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
        end
        report_test("idle after reset", errs_before);

        errs_before = error_count;
        run_job(8, 1'b0);
        report_test("full job T=8", errs_before);

        errs_before = error_count;
        run_job(1, 1'b0);
        run_job(4, 1'b0);
        report_test("short jobs T=1 and T=4", errs_before);

        errs_before = error_count;
        run_job(8, 1'b1);
        report_test("negative scores cleared by relu", errs_before);

        errs_before = error_count;
        repeat (5)
            run_job(rand_range(1, 8), 1'b0);
        report_test("five back-to-back jobs", errs_before);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/attn_types_pkg.sv
hw/attn_ctrl_pkg.sv
hw/attn_loader.sv
hw/dot8_unit.sv
hw/attn_matrix_store.sv
hw/attn_sequencer.sv
hw/attn_top.sv
tests/tb_attn.sv

// ==== Bender.yml ====
package:
  name: attn_engine

sources:
  - files:
      - hw/attn_types_pkg.sv
      - hw/attn_ctrl_pkg.sv
      - hw/attn_loader.sv
      - hw/dot8_unit.sv
      - hw/attn_matrix_store.sv
      - hw/attn_sequencer.sv
      - hw/attn_top.sv
  - target: test
    files:
      - tests/tb_attn.sv
